// File: build.f
source/sifhPkg.sv
source/histSram.sv
source/histBuilder.sv
source/peakFinder.sv
source/filterWindow.sv
source/sifhControl.sv
source/sifhTop.sv
tests/sifhTb.sv

// File: Bender.yml
package:
  name: sifh

sources:
  - source/sifhPkg.sv
  - source/histSram.sv
  - source/histBuilder.sv
  - source/peakFinder.sv
  - source/filterWindow.sv
  - source/sifhControl.sv
  - source/sifhTop.sv
  - target: simulation
    files:
      - tests/sifhTb.sv

// File: tests/sifhTb.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTb;

    localparam int DEPTH = 1 << sifhPkg::BIN_W;
    localparam int MAX_COUNT = (1 << sifhPkg::COUNT_W) - 1;
    localparam int WIN_HALF = 4;
    localparam int NROWS = 7;

    // one row per frame, the first rowHits samples of a pass go to rowMain
    string rowName [NROWS] = '{"strongPeak", "clampLow", "clampHigh", "farCluster",
        "equalBins", "saturate", "sampleGaps"};
    int rowSamples [NROWS] = '{100, 80, 80, 60, 40, 320, 120};
    int rowMain [NROWS] = '{20, 1, 62, 10, 33, 7, 45};
    int rowHits [NROWS] = '{40, 30, 30, 30, 20, 300, 50};
    int rowBgBase [NROWS] = '{0, 0, 52, 50, 30, 0, 0};
    int rowBgSpread [NROWS] = '{64, 12, 12, 3, 1, 64, 64};
    int rowGap [NROWS] = '{0, 10, 10, 0, 0, 0, 40};  // percent of idle cycles

    logic clk;
    logic res;
    logic start;
    sifhPkg::sampleCntT frameSamples;
    logic sampleValid;
    sifhPkg::binT sampleBin;
    logic wrEn;
    logic busy;
    logic frameDone;
    sifhPkg::binT peakBin1;
    sifhPkg::binT peakBin2;
    sifhPkg::countT peakCount2;

    int seed = 32'h9c852bcc;
    int cycleCnt = 0;
    int cycleLimit = 0;
    int hist1 [DEPTH];  // raw counts of pass 1
    int hist2 [DEPTH];  // raw counts of pass 2, unfiltered

    sifhTop #(.WIN_HALF(WIN_HALF)) i_sifhTop (
        .clk(clk), .res(res), .start(start), .frameSamples(frameSamples),
        .sampleValid(sampleValid), .sampleBin(sampleBin), .wrEn(wrEn), .busy(busy),
        .frameDone(frameDone), .peakBin1(peakBin1), .peakBin2(peakBin2),
        .peakCount2(peakCount2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleLimit > 0 && cycleCnt >= cycleLimit) begin
            $display("timeout: the frames did not finish within %0d cycles", cycleLimit);
            $display("Checks failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check(input string what, input logic [31:0] expected,
        input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s: expected %0d, actual %0d", what, expected, actual);
            $display("Checks failed");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    // saturated bins, lowest bin on a tie, second pass only inside the clamped window
    task automatic expectPeaks(output int bin1, output int bin2, output int cnt2);
        int best;
        int lo;
        int hi;
        int c;
        best = 0;
        bin1 = 0;
        for (int b = 0; b < DEPTH; b++) begin
            c = (hist1[b] > MAX_COUNT) ? MAX_COUNT : hist1[b];
            if (c > best) begin
                best = c;
                bin1 = b;
            end
        end
        lo = (bin1 < WIN_HALF) ? 0 : bin1 - WIN_HALF;
        hi = (bin1 > DEPTH - 1 - WIN_HALF) ? DEPTH - 1 : bin1 + WIN_HALF;
        cnt2 = 0;
        bin2 = 0;
        for (int b = lo; b <= hi; b++) begin
            c = (hist2[b] > MAX_COUNT) ? MAX_COUNT : hist2[b];
            if (c > cnt2) begin
                cnt2 = c;
                bin2 = b;
            end
        end
    endtask

    task automatic runFrame(input int t);
        int taken;
        int wrRises;
        int doneCnt;
        int bin1;
        int bin2;
        int cnt2;
        logic wrPrev;
        logic poked;
        sifhPkg::binT code;
        taken = 0;
        wrRises = 0;
        doneCnt = 0;
        wrPrev = 1'b0;
        poked = 1'b0;
        for (int b = 0; b < DEPTH; b++) begin
            hist1[b] = 0;
            hist2[b] = 0;
        end
        frameSamples = sifhPkg::sampleCntT'(rowSamples[t]);
        start = 1'b1;
        @(negedge clk);
        while (doneCnt == 0) begin
            start = 1'b0;
            sampleValid = 1'b0;
            if (frameDone) begin
                doneCnt++;
            end
            check({rowName[t], " busy in frame"}, 1, busy);
            if (wrEn && !wrPrev) begin
                wrRises++;
            end
            if (wrEn && ($unsigned($random(seed)) % 100 >= rowGap[t])) begin
                if (taken % rowSamples[t] < rowHits[t]) begin
                    code = sifhPkg::binT'(rowMain[t]);
                end else begin
                    code = sifhPkg::binT'(rowBgBase[t]
                        + $unsigned($random(seed)) % rowBgSpread[t]);
                end
                sampleBin = code;
                sampleValid = 1'b1;
                if (taken < rowSamples[t]) begin
                    hist1[code]++;
                end else begin
                    hist2[code]++;
                end
                taken++;
            end
            if (wrEn && !poked && taken == rowSamples[t] / 2) begin
                start = 1'b1;  // restart attempt while busy, other length
                frameSamples = sifhPkg::sampleCntT'(rowSamples[t] + 7);
                poked = 1'b1;
            end
            wrPrev = wrEn;
            @(negedge clk);
        end
        expectPeaks(bin1, bin2, cnt2);
        check({rowName[t], " peakBin1"}, bin1, peakBin1);
        check({rowName[t], " peakBin2"}, bin2, peakBin2);
        check({rowName[t], " peakCount2"}, cnt2, peakCount2);
        check({rowName[t], " samples taken"}, 2 * rowSamples[t], taken);
        check({rowName[t], " build phases"}, 2, wrRises);
        repeat (2) begin
            if (frameDone) begin
                doneCnt++;
            end
            check({rowName[t], " wrEn while idle"}, 0, wrEn);
            @(negedge clk);
        end
        check({rowName[t], " frameDone pulses"}, 1, doneCnt);
        check({rowName[t], " busy after frame"}, 0, busy);
    endtask

    initial begin
        res = 1'b0;
        start = 1'b0;
        frameSamples = '0;
        sampleValid = 1'b0;
        sampleBin = '0;
        for (int t = 0; t < NROWS; t++) begin
            // clears and scans, both passes with slack for gaps, drain and idle
            cycleLimit += 4 * DEPTH + 3 * rowSamples[t] * 100 / (100 - rowGap[t]) + 40;
        end
        cycleLimit += 200;
        repeat (5) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        for (int t = 0; t < NROWS; t++) begin
            runFrame(t);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/sifhTop.sv
`timescale 1ns/1ps
`default_nettype none

module sifhTop #(
    parameter int BIN_W = sifhPkg::BIN_W,
    parameter int COUNT_W = sifhPkg::COUNT_W,
    parameter int WIN_HALF = 4
) (
    input  wire                     clk,
    input  wire                     res,
    input  wire                     start,
    input  wire sifhPkg::sampleCntT frameSamples,
    input  wire                     sampleValid,
    input  wire sifhPkg::binT       sampleBin,
    output logic                    wrEn,
    output logic                    busy,
    output logic                    frameDone,
    output sifhPkg::binT            peakBin1,
    output sifhPkg::binT            peakBin2,
    output sifhPkg::countT          peakCount2
);

    logic buildEn;
    logic sampleTake;
    logic scanStart;
    logic scanDone;
    logic latchWin;
    logic inWindow;
    logic bldRe;
    logic bldWe;
    logic scnRe;
    logic re;
    logic we;
    sifhPkg::binT bldRaddr;
    sifhPkg::binT bldWaddr;
    sifhPkg::binT scnRaddr;
    sifhPkg::binT raddr;
    sifhPkg::binT waddr;
    sifhPkg::countT bldWdata;
    sifhPkg::countT wdata;
    sifhPkg::countT rdata;

    sifhControl #(.BIN_W(BIN_W)) i_sifhControl (
        .clk(clk), .res(res), .start(start), .frameSamples(frameSamples),
        .sampleValid(sampleValid), .sampleBin(sampleBin), .inWindow(inWindow),
        .scanDone(scanDone), .bldRe(bldRe), .bldRaddr(bldRaddr), .bldWe(bldWe),
        .bldWaddr(bldWaddr), .bldWdata(bldWdata), .scnRe(scnRe), .scnRaddr(scnRaddr),
        .wrEn(wrEn), .busy(busy), .frameDone(frameDone), .buildEn(buildEn),
        .sampleTake(sampleTake), .scanStart(scanStart), .latchWin(latchWin),
        .re(re), .raddr(raddr), .we(we), .waddr(waddr), .wdata(wdata)
    );

    histSram #(.BIN_W(BIN_W)) i_histSram (
        .clk(clk), .we(we), .waddr(waddr), .wdata(wdata),
        .re(re), .raddr(raddr), .rdata(rdata)
    );

    histBuilder #(.COUNT_W(COUNT_W)) i_histBuilder (
        .clk(clk), .res(res), .buildEn(buildEn), .sampleTake(sampleTake),
        .sampleBin(sampleBin), .rdata(rdata), .bldRe(bldRe), .bldRaddr(bldRaddr),
        .bldWe(bldWe), .bldWaddr(bldWaddr), .bldWdata(bldWdata)
    );

    // same finder serves both passes, the second result stays on its outputs
    peakFinder #(.BIN_W(BIN_W)) i_peakFinder (
        .clk(clk), .res(res), .scanStart(scanStart), .rdata(rdata),
        .scnRe(scnRe), .scnRaddr(scnRaddr), .scanDone(scanDone),
        .peakBin(peakBin2), .peakCount(peakCount2)
    );

    filterWindow #(.BIN_W(BIN_W), .WIN_HALF(WIN_HALF)) i_filterWindow (
        .clk(clk), .res(res), .latchWin(latchWin), .peakBin(peakBin2),
        .sampleBin(sampleBin), .inWindow(inWindow), .peakBin1(peakBin1)
    );

endmodule

`default_nettype wire

// File: source/sifhControl.sv
`timescale 1ns/1ps
`default_nettype none

module sifhControl #(
    parameter int BIN_W = sifhPkg::BIN_W
) (
    input  wire                     clk,
    input  wire                     res,
    input  wire                     start,
    input  wire sifhPkg::sampleCntT frameSamples,
    input  wire                     sampleValid,
    input  wire sifhPkg::binT       sampleBin,
    input  wire                     inWindow,
    input  wire                     scanDone,
    input  wire                     bldRe,
    input  wire sifhPkg::binT       bldRaddr,
    input  wire                     bldWe,
    input  wire sifhPkg::binT       bldWaddr,
    input  wire sifhPkg::countT     bldWdata,
    input  wire                     scnRe,
    input  wire sifhPkg::binT       scnRaddr,
    output logic                    wrEn,
    output logic                    busy,
    output logic                    frameDone,
    output logic                    buildEn,
    output logic                    sampleTake,
    output logic                    scanStart,
    output logic                    latchWin,
    output logic                    re,
    output sifhPkg::binT            raddr,
    output logic                    we,
    output sifhPkg::binT            waddr,
    output sifhPkg::countT          wdata
);

    localparam sifhPkg::binT LAST_ADDR = sifhPkg::binT'((1 << BIN_W) - 1);

    sifhPkg::phaseT phase;
    sifhPkg::phaseT phaseNext;
    sifhPkg::sampleCntT frameLimit;
    sifhPkg::sampleCntT sampleCnt;
    sifhPkg::binT clrAddr;
    logic [1:0] drainCnt;
    logic inClear;
    logic inBuild;
    logic inDrain;
    logic inPeak;
    logic take;
    logic lastSample;

    assign inClear = (phase == sifhPkg::CLEAR1) || (phase == sifhPkg::CLEAR2);
    assign inBuild = (phase == sifhPkg::BUILD1) || (phase == sifhPkg::BUILD2);
    assign inDrain = (phase == sifhPkg::DRAIN1) || (phase == sifhPkg::DRAIN2);
    assign inPeak = (phase == sifhPkg::PEAK1) || (phase == sifhPkg::PEAK2);

    assign wrEn = inBuild && (frameLimit != '0);  // tdc may deliver
    assign take = sampleValid && wrEn;
    assign lastSample = take && (sampleCnt == frameLimit - 1'b1);
    // out-of-window codes still count toward the frame
    assign sampleTake = take && ((phase == sifhPkg::BUILD1) || inWindow);
    assign buildEn = inBuild || inDrain;  // pipeline still writing in drain
    assign scanStart = inDrain && (drainCnt == 2'd2);
    assign latchWin = (phase == sifhPkg::WINDOW);
    assign busy = (phase != sifhPkg::IDLE);
    assign frameDone = (phase == sifhPkg::DONE);

    always_comb begin
        phaseNext = phase;
        case (phase)
            sifhPkg::IDLE:   if (start) phaseNext = sifhPkg::CLEAR1;
            sifhPkg::CLEAR1: if (clrAddr == LAST_ADDR) phaseNext = sifhPkg::BUILD1;
            sifhPkg::BUILD1: if (frameLimit == '0 || lastSample) phaseNext = sifhPkg::DRAIN1;
            sifhPkg::DRAIN1: if (drainCnt == 2'd2) phaseNext = sifhPkg::PEAK1;
            sifhPkg::PEAK1:  if (scanDone) phaseNext = sifhPkg::WINDOW;
            sifhPkg::WINDOW: phaseNext = sifhPkg::CLEAR2;
            sifhPkg::CLEAR2: if (clrAddr == LAST_ADDR) phaseNext = sifhPkg::BUILD2;
            sifhPkg::BUILD2: if (frameLimit == '0 || lastSample) phaseNext = sifhPkg::DRAIN2;
            sifhPkg::DRAIN2: if (drainCnt == 2'd2) phaseNext = sifhPkg::PEAK2;
            sifhPkg::PEAK2:  if (scanDone) phaseNext = sifhPkg::DONE;
            default:         phaseNext = sifhPkg::IDLE;  // done lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase <= sifhPkg::IDLE;
            frameLimit <= '0;
            sampleCnt <= '0;
            clrAddr <= '0;
            drainCnt <= '0;
        end else begin
            phase <= phaseNext;
            if ((phase == sifhPkg::IDLE) && start) begin
                frameLimit <= frameSamples;  // start while busy is dropped
            end
            if (inClear) begin
                sampleCnt <= '0;
            end else if (take) begin
                sampleCnt <= sampleCnt + 1'b1;
            end
            clrAddr <= inClear ? clrAddr + 1'b1 : '0;  // wraps to 0 at the end
            drainCnt <= inDrain ? drainCnt + 1'b1 : '0;
        end
    end

    // sram port owner by phase
    always_comb begin
        re = 1'b0;
        raddr = bldRaddr;
        we = 1'b0;
        waddr = bldWaddr;
        wdata = bldWdata;
        if (inClear) begin
            we = 1'b1;
            waddr = clrAddr;
            wdata = '0;
        end else if (buildEn) begin
            re = bldRe;
            we = bldWe;
        end else if (inPeak) begin
            re = scnRe;
            raddr = scnRaddr;
        end
    end

    oneSramOwner : assert property (@(posedge clk) disable iff (!res)
        $onehot0({inClear, bldRe || bldWe, scnRe}));
    noScanWrite : assert property (@(posedge clk) disable iff (!res) scnRe |-> !we);
    knownSample : assert property (@(posedge clk) disable iff (!res)
        take |-> !$isunknown(sampleBin));

endmodule

`default_nettype wire

// File: source/filterWindow.sv
`timescale 1ns/1ps
`default_nettype none

module filterWindow #(
    parameter int BIN_W = sifhPkg::BIN_W,
    parameter int WIN_HALF = 4
) (
    input  wire               clk,
    input  wire               res,
    input  wire               latchWin,
    input  wire sifhPkg::binT peakBin,
    input  wire sifhPkg::binT sampleBin,
    output logic              inWindow,
    output sifhPkg::binT      peakBin1
);

    localparam sifhPkg::binT LAST_BIN = sifhPkg::binT'((1 << BIN_W) - 1);
    localparam sifhPkg::binT HALF = sifhPkg::binT'(WIN_HALF);

    sifhPkg::binT thLo;
    sifhPkg::binT thHi;
    sifhPkg::binT loNext;
    sifhPkg::binT hiNext;

    // clamp at both ends of the bin range
    assign loNext = (peakBin < HALF) ? '0 : peakBin - HALF;
    assign hiNext = (peakBin > LAST_BIN - HALF) ? LAST_BIN : peakBin + HALF;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakBin1 <= '0;
            thLo <= '0;
            thHi <= LAST_BIN;  // open window until the first peak
        end else if (latchWin) begin
            peakBin1 <= peakBin;
            thLo <= loNext;
            thHi <= hiNext;
        end
    end

    assign inWindow = (sampleBin >= thLo) && (sampleBin <= thHi);  // inclusive

endmodule

`default_nettype wire

// File: source/peakFinder.sv
`timescale 1ns/1ps
`default_nettype none

module peakFinder #(
    parameter int BIN_W = sifhPkg::BIN_W
) (
    input  wire                 clk,
    input  wire                 res,
    input  wire                 scanStart,
    input  wire sifhPkg::countT rdata,
    output logic                scnRe,
    output sifhPkg::binT        scnRaddr,
    output logic                scanDone,
    output sifhPkg::binT        peakBin,
    output sifhPkg::countT      peakCount
);

    localparam int DEPTH = 1 << BIN_W;
    localparam sifhPkg::binT LAST_ADDR = sifhPkg::binT'(DEPTH - 1);

    logic scanning;
    logic dValid;
    logic dLast;
    sifhPkg::binT scanAddr;
    sifhPkg::binT dAddr;

    assign scnRe = scanning;
    assign scnRaddr = scanAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            scanAddr <= '0;
            dValid <= 1'b0;
            dLast <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            dValid <= scanning;  // rdata valid next cycle
            dLast <= scanning && (scanAddr == LAST_ADDR);
            scanDone <= dValid && dLast;
            if (scanStart) begin
                scanning <= 1'b1;
                scanAddr <= '0;
            end else if (scanning) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == LAST_ADDR) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // address that goes with the current rdata
    always_ff @(posedge clk) begin
        dAddr <= scanAddr;
    end

    // ascending walk and strict compare keep the lowest bin on a tie
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakBin <= '0;
            peakCount <= '0;
        end else if (scanStart) begin
            peakBin <= '0;
            peakCount <= '0;
        end else if (dValid && (rdata > peakCount)) begin
            peakBin <= dAddr;
            peakCount <= rdata;
        end
    end

    // fixed scan length, one cycle per bin plus the read and compare stages
    scanLength : assert property (@(posedge clk) disable iff (!res)
        scanStart |-> ##(DEPTH + 2) scanDone);

endmodule

`default_nettype wire

// File: source/histBuilder.sv
`timescale 1ns/1ps
`default_nettype none

module histBuilder #(
    parameter int COUNT_W = sifhPkg::COUNT_W
) (
    input  wire                 clk,
    input  wire                 res,
    input  wire                 buildEn,
    input  wire                 sampleTake,
    input  wire sifhPkg::binT   sampleBin,
    input  wire sifhPkg::countT rdata,
    output logic                bldRe,
    output sifhPkg::binT        bldRaddr,
    output logic                bldWe,
    output sifhPkg::binT        bldWaddr,
    output sifhPkg::countT      bldWdata
);

    localparam sifhPkg::countT MAX_COUNT = sifhPkg::countT'((1 << COUNT_W) - 1);

    logic issue;
    logic hitS1;
    logic hitS2;
    logic s1Valid;
    logic s1Fwd;
    logic s2Valid;
    sifhPkg::binT s1Bin;
    sifhPkg::binT s2Bin;
    sifhPkg::countT s1FwdVal;
    sifhPkg::countT s2Val;
    sifhPkg::countT curVal;
    sifhPkg::countT nextVal;

    // stage 0 issues the read
    assign issue = sampleTake && buildEn;
    assign bldRe = issue;
    assign bldRaddr = sampleBin;

    // same bin already in flight, its sram word is stale for this read
    assign hitS1 = s1Valid && (s1Bin == sampleBin);  // value still being computed
    assign hitS2 = s2Valid && (s2Bin == sampleBin);  // write lands on the read edge

    // stage 1, data back from sram or from the pipeline
    assign curVal = s1Fwd ? s1FwdVal : rdata;
    assign nextVal = (curVal == MAX_COUNT) ? curVal : curVal + 1'b1;  // saturate

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s1Fwd <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= issue;
            s1Fwd <= issue && (hitS1 || hitS2);
            s2Valid <= s1Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= sampleBin;
        if (hitS1) begin
            s1FwdVal <= nextVal;  // newest value wins
        end else begin
            s1FwdVal <= s2Val;
        end
        s2Bin <= s1Bin;
        s2Val <= nextVal;
    end

    // stage 2 writes back
    assign bldWe = s2Valid;
    assign bldWaddr = s2Bin;
    assign bldWdata = s2Val;

    // back-to-back writes to one bin keep climbing until saturation
    countMonotonic : assert property (@(posedge clk) disable iff (!res)
        bldWe && $past(bldWe) && (bldWaddr == $past(bldWaddr))
            |-> (bldWdata > $past(bldWdata)) || (bldWdata == MAX_COUNT));

endmodule

`default_nettype wire

// File: source/histSram.sv
`timescale 1ns/1ps
`default_nettype none

module histSram #(
    parameter int BIN_W = sifhPkg::BIN_W
) (
    input  wire                 clk,
    input  wire                 we,
    input  wire sifhPkg::binT   waddr,
    input  wire sifhPkg::countT wdata,
    input  wire                 re,
    input  wire sifhPkg::binT   raddr,
    output sifhPkg::countT      rdata
);

    localparam int DEPTH = 1 << BIN_W;

    sifhPkg::countT mem [DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];  // one cycle latency
        end
    end

    writeAddrKnown : assert property (@(posedge clk) we |-> !$isunknown(waddr));
    readAddrKnown : assert property (@(posedge clk) re |-> !$isunknown(raddr));

endmodule

`default_nettype wire

// File: source/sifhPkg.sv
`default_nettype none

package sifhPkg;

    localparam int BIN_W = 6;    // 64 time bins
    localparam int COUNT_W = 8;  // counts saturate at 255

    typedef logic [BIN_W-1:0] binT;      // tdc code, also the sram address
    typedef logic [COUNT_W-1:0] countT;  // one bin count
    typedef logic [15:0] sampleCntT;     // samples per frame

    // frame phases, each pass is clear -> build -> drain -> peak scan
    typedef enum logic [3:0] {
        IDLE,
        CLEAR1,
        BUILD1,
        DRAIN1,
        PEAK1,
        WINDOW,
        CLEAR2,
        BUILD2,
        DRAIN2,
        PEAK2,
        DONE
    } phaseT;

endpackage

`default_nettype wire
